// File: design/scorePkg.sv
`default_nettype none

package scorePkg;

	//////////////////////////////
	// Screen placement

	localparam int CoordWidth = 16;

	localparam logic [CoordWidth-1:0] PipePassX = 16'd10;
	localparam int ScoreBaseX = 320;
	localparam logic [CoordWidth-1:0] ScoreBaseY = 16'd50;
	localparam logic [CoordWidth-1:0] ScoreOverY = 16'd185;

	localparam int CellScale = 3;
	localparam int GlyphCols = 9;
	localparam int GlyphRows = 14;
	localparam int DigitCount = 10;

	localparam int UnitOffsetX = 3;
	localparam int TenOffsetX = -30;

	// Window size in pixels
	localparam int GlyphWidth = GlyphCols * CellScale;
	localparam int GlyphHeight = GlyphRows * CellScale;

	localparam logic [CoordWidth-1:0] UnitLeftX = CoordWidth'(ScoreBaseX + UnitOffsetX);
	localparam logic [CoordWidth-1:0] TenLeftX = CoordWidth'(ScoreBaseX + TenOffsetX);

	//////////////////////////////
	// Pipeline payloads

	typedef logic [3:0] bcdDigit;

	typedef struct packed {
		logic [CoordWidth-1:0] x;
		logic [CoordWidth-1:0] y;
	} pixelPos;

	typedef struct packed {
		bcdDigit tens;
		bcdDigit units;
		logic [CoordWidth-1:0] top;
	} scoreState;

	typedef struct packed {
		logic valid;
		bcdDigit digit;
		logic [3:0] col;
		logic [3:0] row;
	} cellHit;

	//////////////////////////////
	// Glyph bitmaps

	// Leftmost bit of a row mask is cell column 0
	typedef logic [GlyphCols-1:0] glyphRow;

	localparam glyphRow OutlineGlyph [DigitCount][GlyphRows] = '{
		'{9'b111111111, 9'b100000001, 9'b100000001, 9'b100000001, 9'b100010001,
		  9'b100010001, 9'b100010001, 9'b100010001, 9'b100010001, 9'b100010001,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b111111111},
		'{9'b001111110, 9'b001000010, 9'b001000010, 9'b001000010, 9'b001100010,
		  9'b000100010, 9'b000100010, 9'b000100010, 9'b000100010, 9'b000100010,
		  9'b000100010, 9'b000100010, 9'b000100010, 9'b000111110},
		'{9'b111111111, 9'b100000001, 9'b100000001, 9'b100000001, 9'b111110001,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b100000001, 9'b100011111,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b111111111},
		'{9'b111111111, 9'b100000001, 9'b100000001, 9'b100000001, 9'b111110001,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b100000001, 9'b111110001,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b111111111},
		'{9'b111111111, 9'b100010001, 9'b100010001, 9'b100010001, 9'b100010001,
		  9'b100010001, 9'b100000001, 9'b100000001, 9'b100000001, 9'b111110001,
		  9'b000010001, 9'b000010001, 9'b000010001, 9'b000011111},
		'{9'b111111111, 9'b100000001, 9'b100000001, 9'b100000001, 9'b100011111,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b100000001, 9'b111110001,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b111111111},
		'{9'b111111111, 9'b100000001, 9'b100000001, 9'b100000001, 9'b100011111,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b100000001, 9'b100010001,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b111111111},
		'{9'b111111111, 9'b100000001, 9'b100000001, 9'b100000001, 9'b111110001,
		  9'b000010001, 9'b000010001, 9'b000010001, 9'b000010001, 9'b000010001,
		  9'b000010001, 9'b000010001, 9'b000010001, 9'b000011111},
		'{9'b111111111, 9'b100000001, 9'b100000001, 9'b100000001, 9'b100010001,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b100000001, 9'b100010001,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b111111111},
		'{9'b111111111, 9'b100000001, 9'b100000001, 9'b100000001, 9'b100010001,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b100000001, 9'b111110001,
		  9'b100000001, 9'b100000001, 9'b100000001, 9'b111111111}
	};

	localparam glyphRow FillGlyph [DigitCount][GlyphRows] = '{
		'{9'b000000000, 9'b011111110, 9'b011111110, 9'b011111110, 9'b011101110,
		  9'b011101110, 9'b011101110, 9'b011101110, 9'b011101110, 9'b011101110,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b000000000},
		'{9'b000000000, 9'b000111100, 9'b000111100, 9'b000111100, 9'b000011100,
		  9'b000011100, 9'b000011100, 9'b000011100, 9'b000011100, 9'b000011100,
		  9'b000011100, 9'b000011100, 9'b000011100, 9'b000000000},
		'{9'b000000000, 9'b011111110, 9'b011111110, 9'b011111110, 9'b000001110,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b011111110, 9'b011100000,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b000000000},
		'{9'b000000000, 9'b011111110, 9'b011111110, 9'b011111110, 9'b000001110,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b011111110, 9'b000001110,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b000000000},
		'{9'b000000000, 9'b011101110, 9'b011101110, 9'b011101110, 9'b011101110,
		  9'b011101110, 9'b011111110, 9'b011111110, 9'b011111110, 9'b000001110,
		  9'b000001110, 9'b000001110, 9'b000001110, 9'b000000000},
		'{9'b000000000, 9'b011111110, 9'b011111110, 9'b011111110, 9'b011100000,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b011111110, 9'b000001110,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b000000000},
		'{9'b000000000, 9'b011111110, 9'b011111110, 9'b011111110, 9'b011100000,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b011111110, 9'b011101110,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b000000000},
		'{9'b000000000, 9'b011111110, 9'b011111110, 9'b011111110, 9'b000001110,
		  9'b000001110, 9'b000001110, 9'b000001110, 9'b000001110, 9'b000001110,
		  9'b000001110, 9'b000001110, 9'b000001110, 9'b000000000},
		'{9'b000000000, 9'b011111110, 9'b011111110, 9'b011111110, 9'b011101110,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b011111110, 9'b011101110,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b000000000},
		'{9'b000000000, 9'b011111110, 9'b011111110, 9'b011111110, 9'b011101110,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b011111110, 9'b000001110,
		  9'b011111110, 9'b011111110, 9'b011111110, 9'b000000000}
	};

endpackage

`default_nettype wire

// File: design/scoreKeeper.sv
`default_nettype none

module scoreKeeper (
	input logic Clks,
	input logic reset,
	input logic [scorePkg::CoordWidth-1:0] pipeOne,
	input logic [scorePkg::CoordWidth-1:0] pipeTwo,
	input logic gameOver,
	output scorePkg::scoreState score
);
	import scorePkg::*;

	logic atPass;
	logic atPassPrev;
	logic pass;

	// Either pipe sitting on the pass column
	assign atPass = (pipeOne == PipePassX) || (pipeTwo == PipePassX);

	// Only the first cycle at the column counts
	assign pass = atPass && !atPassPrev;

	//////////////////////////////
	// Two-digit BCD count

	always_ff @(posedge Clks) begin
		if (reset) begin
			atPassPrev <= 1'b0;
			score.tens <= 4'd0;
			score.units <= 4'd0;
		end else begin
			atPassPrev <= atPass;
			if (pass) begin
				if (score.units == 4'd9) begin
					score.units <= 4'd0;
					// 99 rolls over to 00
					if (score.tens == 4'd9)
						score.tens <= 4'd0;
					else
						score.tens <= score.tens + 4'd1;
				end else begin
					score.units <= score.units + 4'd1;
				end
			end
		end
	end

	//////////////////////////////
	// Window top edge

	always_ff @(posedge Clks) begin
		if (reset)
			score.top <= ScoreBaseY;
		else if (gameOver)
			score.top <= ScoreOverY;
		else
			score.top <= ScoreBaseY;
	end

endmodule

`default_nettype wire

// File: design/digitLocate.sv
`default_nettype none

module digitLocate (
	input logic Clks,
	input logic reset,
	input scorePkg::pixelPos pixel,
	input scorePkg::scoreState score,
	output scorePkg::cellHit hit
);
	import scorePkg::*;

	logic [CoordWidth-1:0] unitDx;
	logic [CoordWidth-1:0] tenDx;
	logic [CoordWidth-1:0] rowDy;
	logic [CoordWidth-1:0] cellDx;
	logic rowIn;
	logic inUnits;
	logic inTens;
	cellHit hitNext;

	//////////////////////////////
	// Window test

	always_comb begin
		// Offsets left of or above a window wrap to large values
		unitDx = pixel.x - UnitLeftX;
		tenDx = pixel.x - TenLeftX;
		rowDy = pixel.y - score.top;

		rowIn = rowDy < GlyphHeight;
		inUnits = rowIn && (unitDx < GlyphWidth);
		// Leading zero stays blank
		inTens = rowIn && (tenDx < GlyphWidth) && (score.tens != 4'd0);

		cellDx = inTens ? tenDx : unitDx;

		hitNext = '0;
		if (inUnits || inTens) begin
			hitNext.valid = 1'b1;
			hitNext.digit = inTens ? score.tens : score.units;
			hitNext.col = 4'(cellDx / CellScale);
			hitNext.row = 4'(rowDy / CellScale);
		end
	end

	always_ff @(posedge Clks) begin
		if (reset)
			hit <= '0;
		else
			hit <= hitNext;
	end

endmodule

`default_nettype wire

// File: design/glyphShade.sv
`default_nettype none

module glyphShade (
	input logic Clks,
	input logic reset,
	input scorePkg::cellHit hit,
	output logic outline,
	output logic fill
);
	import scorePkg::*;

	glyphRow outlineRow;
	glyphRow fillRow;
	logic outlineBit;
	logic fillBit;

	//////////////////////////////
	// Table lookup

	always_comb begin
		outlineRow = OutlineGlyph[hit.digit][hit.row];
		fillRow = FillGlyph[hit.digit][hit.row];
		// Column 0 sits in the top bit of the mask
		outlineBit = outlineRow[GlyphCols - 1 - hit.col];
		fillBit = fillRow[GlyphCols - 1 - hit.col];
	end

	always_ff @(posedge Clks) begin
		if (reset) begin
			outline <= 1'b0;
			fill <= 1'b0;
		end else begin
			outline <= hit.valid && outlineBit;
			fill <= hit.valid && fillBit;
		end
	end

endmodule

`default_nettype wire

// File: design/scoreDisplay.sv
`default_nettype none

module scoreDisplay (
	input logic Clks,
	input logic reset,
	input logic [scorePkg::CoordWidth-1:0] pipeOne,
	input logic [scorePkg::CoordWidth-1:0] pipeTwo,
	input logic gameOver,
	input scorePkg::pixelPos pixel,
	output logic scoreOutline,
	output logic scoreFill,
	output scorePkg::bcdDigit tens,
	output scorePkg::bcdDigit units
);
	import scorePkg::*;

	scoreState score;
	cellHit hit;

	assign tens = score.tens;
	assign units = score.units;

	scoreKeeper i_scoreKeeper (
		.Clks(Clks),
		.reset(reset),
		.pipeOne(pipeOne),
		.pipeTwo(pipeTwo),
		.gameOver(gameOver),
		.score(score)
	);

	// Pixel to cell, one cycle
	digitLocate i_digitLocate (
		.Clks(Clks),
		.reset(reset),
		.pixel(pixel),
		.score(score),
		.hit(hit)
	);

	glyphShade i_glyphShade (
		.Clks(Clks),
		.reset(reset),
		.hit(hit),
		.outline(scoreOutline),
		.fill(scoreFill)
	);

endmodule

`default_nettype wire

// File: verif/scoreDisplay_sva.sv
`default_nettype none

module scoreDisplaySva (
	input logic Clks,
	input logic reset,
	input logic pass,
	input scorePkg::scoreState score
);
	timeunit 1ns;
	timeprecision 1ps;

	import scorePkg::*;

	//////////////////////////////
	// Score register

	// Both digits stay decimal
	bcdRange: assert property (@(posedge Clks) disable iff (reset)
		(score.tens <= 4'd9) && (score.units <= 4'd9))
		else $error("score digit outside 0 to 9");

	holdWithoutPass: assert property (@(posedge Clks) disable iff (reset)
		!pass |=> $stable({score.tens, score.units}))
		else $error("score changed without a pass");

	stepOnPass: assert property (@(posedge Clks) disable iff (reset)
		pass |=> !$stable({score.tens, score.units}))
		else $error("pass did not move the score");

	// Cleared count and playing position out of reset
	clearAfterReset: assert property (@(posedge Clks)
		reset |=> (score.tens == 4'd0) && (score.units == 4'd0) && (score.top == ScoreBaseY))
		else $error("score state not cleared by reset");

endmodule

bind scoreKeeper scoreDisplaySva i_scoreDisplaySva (
	.Clks(Clks),
	.reset(reset),
	.pass(pass),
	.score(score)
);

`default_nettype wire

// File: verif/scoreDisplayTb.sv
`default_nettype none

module scoreDisplayTb;
	timeunit 1ns;
	timeprecision 1ps;

	import scorePkg::*;

	localparam string StimFile = "verif/scoreStim.txt";
	localparam int ResetCycles = 8;
	localparam int ProbeDelay = 2;
	localparam int RandomGapBits = 3;
	localparam int RandomGapMax = 1 << RandomGapBits;
	localparam int TimeoutMargin = 100;
	localparam logic [31:0] LfsrSeed = 32'h757f72c9;
	localparam logic [CoordWidth-1:0] PipeIdle = 16'd100;

	logic Clks;
	logic reset;
	logic [CoordWidth-1:0] pipeOne;
	logic [CoordWidth-1:0] pipeTwo;
	logic gameOver;
	pixelPos pixel;
	logic scoreOutline;
	logic scoreFill;
	bcdDigit tens;
	bcdDigit units;

	// One entry per command line of the stimulus file
	byte cmdKind[$];
	int argA[$];
	int argB[$];
	int argC[$];
	int argD[$];
	string cmdName[$];

	// Probes still travelling through the pipeline
	int dueTick[$];
	int probeX[$];
	int probeY[$];
	logic expOutline[$];
	logic expFill[$];

	logic [31:0] lfsrState = LfsrSeed;
	int tickCount = 0;
	int cycleCount = 0;
	int cycleLimit = 100000;
	int testChecks = 0;
	int testErrors = 0;
	int totalChecks = 0;
	int totalErrors = 0;
	int testCount = 0;
	int failedTests = 0;
	string currentTest = "resetHold";
	bit loadOk;

	scoreDisplay i_scoreDisplay (
		.Clks(Clks),
		.reset(reset),
		.pipeOne(pipeOne),
		.pipeTwo(pipeTwo),
		.gameOver(gameOver),
		.pixel(pixel),
		.scoreOutline(scoreOutline),
		.scoreFill(scoreFill),
		.tens(tens),
		.units(units)
	);

	always #50 Clks = ~Clks;

	always @(posedge Clks) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: run still busy after %0d cycles", cycleLimit);
			$display("STATUS: FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Random gap source

	function automatic logic [31:0] nextLfsr(input logic [31:0] state);
		logic feedback;
		feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
		return {state[30:0], feedback};
	endfunction

	task automatic drawRandomGap(output int gap);
		int i;
		gap = 0;
		for (i = 0; i < RandomGapBits; i++) begin
			lfsrState = nextLfsr(lfsrState);
			gap = (gap << 1) | int'(lfsrState[0]);
		end
		gap = gap + 1;
	endtask

	//////////////////////////////
	// Stimulus file

	function automatic string trimEnd(input string s);
		int last;
		last = s.len() - 1;
		while (last >= 0 && (s.getc(last) == 8'h0a || s.getc(last) == 8'h0d
				|| s.getc(last) == 8'h20))
			last--;
		return (last < 0) ? "" : s.substr(0, last);
	endfunction

	task automatic loadStimulus(output bit ok);
		int fd;
		int n;
		int a;
		int b;
		int c;
		int d;
		int cost;
		int longest;
		byte kind;
		string line;
		string body;
		ok = 1'b0;
		longest = 1;
		fd = $fopen(StimFile, "r");
		if (fd == 0) begin
			$display("Could not open stimulus file %s", StimFile);
		end else begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				line = trimEnd(line);
				if (line.len() == 0 || line.getc(0) == "#")
					continue;
				kind = line.getc(0);
				body = (line.len() > 2) ? line.substr(2, line.len() - 1) : "";
				a = 0;
				b = 0;
				c = 0;
				d = 0;
				if (kind != "T")
					n = $sscanf(body, "%d %d %d %d", a, b, c, d);
				cmdKind.push_back(kind);
				cmdName.push_back(body);
				argA.push_back(a);
				argB.push_back(b);
				argC.push_back(c);
				argD.push_back(d);
				// Longest stretch of cycles one line can take
				cost = (kind == "P") ? d * (b + ((c == 0) ? RandomGapMax : c) + 1) : 1;
				if (cost > longest)
					longest = cost;
			end
			$fclose(fd);
			cycleLimit = ResetCycles + cmdKind.size() * (longest + ProbeDelay) + TimeoutMargin;
			ok = (cmdKind.size() > 0);
		end
	endtask

	//////////////////////////////
	// Cycle stepping and checks

	task automatic checkDueProbes();
		while (dueTick.size() > 0 && dueTick[0] <= tickCount) begin
			testChecks += 2;
			if (scoreOutline !== expOutline[0]) begin
				$display("Error: scoreOutline expected 0x%h got 0x%h for pixel (%0d, %0d)",
					expOutline[0], scoreOutline, probeX[0], probeY[0]);
				testErrors++;
			end
			if (scoreFill !== expFill[0]) begin
				$display("Error: scoreFill expected 0x%h got 0x%h for pixel (%0d, %0d)",
					expFill[0], scoreFill, probeX[0], probeY[0]);
				testErrors++;
			end
			void'(dueTick.pop_front());
			void'(probeX.pop_front());
			void'(probeY.pop_front());
			void'(expOutline.pop_front());
			void'(expFill.pop_front());
		end
	endtask

	task automatic nextCycle();
		@(negedge Clks);
		tickCount++;
		checkDueProbes();
	endtask

	task automatic checkOutputsLow();
		testChecks++;
		if (scoreOutline !== 1'b0 || scoreFill !== 1'b0) begin
			$display("Error: scoreOutline/scoreFill expected 0x0/0x0 got 0x%h/0x%h in cycle %0d",
				scoreOutline, scoreFill, tickCount);
			testErrors++;
		end
	endtask

	task automatic finishTest();
		while (dueTick.size() > 0)
			nextCycle();
		testCount++;
		totalChecks += testChecks;
		totalErrors += testErrors;
		if (testErrors != 0) begin
			failedTests++;
			$display("Test %s: %0d checks, %0d errors, failed", currentTest, testChecks, testErrors);
		end else begin
			$display("Test %s: %0d checks, ok", currentTest, testChecks);
		end
		testChecks = 0;
		testErrors = 0;
	endtask

	//////////////////////////////
	// Command handlers

	// Pixel parked on a units cell so the reset gating shows
	task automatic applyReset();
		int i;
		reset = 1'b1;
		for (i = 0; i < ResetCycles; i++) begin
			nextCycle();
			checkOutputsLow();
		end
		reset = 1'b0;
		nextCycle();
		checkOutputsLow();
		pixel = '0;
	endtask

	task automatic runPass(input int pipe, input int hold, input int gap, input int count);
		int rep;
		int idle;
		int i;
		for (rep = 0; rep < count; rep++) begin
			nextCycle();
			if (pipe == 1 || pipe == 3)
				pipeOne = PipePassX;
			if (pipe == 2 || pipe == 3)
				pipeTwo = PipePassX;
			for (i = 1; i < hold; i++)
				nextCycle();
			nextCycle();
			pipeOne = PipeIdle;
			pipeTwo = PipeIdle;
			if (gap == 0)
				drawRandomGap(idle);
			else
				idle = gap;
			for (i = 0; i < idle; i++)
				nextCycle();
		end
	endtask

	task automatic runCommands();
		int idx;
		for (idx = 0; idx < cmdKind.size(); idx++) begin
			case (cmdKind[idx])
				"T": begin
					finishTest();
					currentTest = cmdName[idx];
				end
				"P": runPass(argA[idx], argB[idx], argC[idx], argD[idx]);
				"G": begin
					nextCycle();
					gameOver = (argA[idx] != 0);
				end
				"X": begin
					nextCycle();
					pixel.x = CoordWidth'(argA[idx]);
					pixel.y = CoordWidth'(argB[idx]);
					dueTick.push_back(tickCount + ProbeDelay);
					probeX.push_back(argA[idx]);
					probeY.push_back(argB[idx]);
					expOutline.push_back(argC[idx] != 0);
					expFill.push_back(argD[idx] != 0);
				end
				"S": begin
					nextCycle();
					testChecks += 2;
					if (tens !== bcdDigit'(argA[idx])) begin
						$display("Error: tens expected 0x%h got 0x%h", bcdDigit'(argA[idx]), tens);
						testErrors++;
					end
					if (units !== bcdDigit'(argB[idx])) begin
						$display("Error: units expected 0x%h got 0x%h", bcdDigit'(argB[idx]), units);
						testErrors++;
					end
				end
				default: begin
					$display("Stimulus command %s is not understood", cmdName[idx]);
					testErrors++;
				end
			endcase
		end
		finishTest();
	endtask

	initial begin
		Clks = 1'b0;
		reset = 1'b1;
		pipeOne = PipeIdle;
		pipeTwo = PipeIdle;
		gameOver = 1'b0;
		pixel.x = UnitLeftX;
		pixel.y = ScoreBaseY;
		loadStimulus(loadOk);
		if (loadOk) begin
			applyReset();
			runCommands();
		end else begin
			$display("No stimulus loaded, nothing was tested");
			totalErrors++;
		end
		$display("Tests %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, totalChecks, totalErrors);
		if (totalErrors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/scoreStim.txt
# T name | P pipe hold gap repeat (pipe 1, 2 or 3 for both, gap 0 takes a random gap)
# G gameOver | X x y outline fill | S tens units   (all fields decimal)
T resetState
S 0 0
X 0 0 0 0
X 291 51 0 0
X 323 50 1 0
X 326 53 0 1
X 335 62 1 0
X 350 50 0 0
X 322 60 0 0
X 323 92 0 0
T counting
P 1 1 4 1
S 0 1
P 2 5 0 1
S 0 2
P 3 2 0 1
S 0 3
P 1 1 0 6
S 0 9
P 2 1 3 1
S 1 0
T unitsGlyph
P 1 1 0 3
S 1 3
X 323 50 1 0
X 326 53 0 1
X 329 62 1 0
X 341 62 0 1
X 349 91 1 0
X 324 66 1 0
X 350 60 0 0
X 322 60 0 0
T tensGlyph
X 290 50 0 0
X 296 50 1 0
X 299 53 0 1
X 305 68 0 1
X 311 68 1 0
X 289 60 0 0
X 317 60 0 0
T wrap
P 1 1 0 86
S 9 9
X 290 50 1 0
X 335 77 1 0
X 341 77 0 1
P 2 1 2 1
S 0 0
X 296 51 0 0
X 323 50 1 0
T gameOver
P 1 1 0 17
S 1 7
G 1
X 323 50 0 0
X 323 185 1 0
X 326 188 0 1
X 338 200 0 1
X 335 200 1 0
X 347 224 1 0
X 323 224 0 0
X 290 185 0 0
X 296 185 1 0
X 296 50 0 0
G 0
X 323 50 1 0
X 323 185 0 0
S 1 7

// File: scoreDisplay.f
design/scorePkg.sv
design/scoreKeeper.sv
design/digitLocate.sv
design/glyphShade.sv
design/scoreDisplay.sv
verif/scoreDisplay_sva.sv
verif/scoreDisplayTb.sv

// File: Makefile
# Verilator build and run for the score overlay

VERILATOR ?= verilator
TOP ?= scoreDisplayTb
FILELIST ?= scoreDisplay.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
STIM ?= verif/scoreStim.txt
VERILATOR_FLAGS ?= --binary --timing --assert -Wno-fatal

FAIL_TEXT = STATUS: FAIL
PASS_TEXT = STATUS: PASS

SOURCES := $(shell cat $(FILELIST))
SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN) $(STIM)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; \
		exit 1; \
	fi
	@if grep -q "$(FAIL_TEXT)" $(LOG); then \
		echo "Failure reported in $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "No final result found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
